// ==== Bender.yml ====
package:
  name: core_backend

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_pkg.sv
      - hw/inst_decode.sv
      - hw/int_alu.sv
      - hw/ex_mem_reg.sv
      - hw/data_mem_stage.sv
      - hw/reg_file.sv
      - hw/core_backend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/core_backend_tb.sv

// ==== hw/core_backend.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module core_backend
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [31:0]      pc,
    output logic             inst_ready,
    output logic             retire_valid,
    output logic [31:0]      retire_pc,
    output logic [4:0]       retire_rd,
    output logic [`XLEN-1:0] retire_data
);

    logic [4:0]       rs1, rs2;
    logic [`XLEN-1:0] rs1_data, rs2_data;

    logic             id_valid, id_rd_idx_0, id_rd_w_en, id_inst_load, id_inst_store;
    logic [2:0]       id_funct3;
    logic [31:0]      id_pc, id_inst;
    logic [4:0]       id_rs1, id_rs2, id_rd;
    logic [`XLEN-1:0] id_x_rs1, id_x_rs2, id_imm;
    alu_op_e          id_alu_op;
    logic [`XLEN-1:0] exu_result;

    logic             mem_valid, mem_ready, mem_idle;
    logic             mem_rd_idx_0, mem_rd_w_en, mem_inst_load, mem_inst_store;
    logic [2:0]       mem_funct3;
    logic [31:0]      mem_pc;
    logic [4:0]       mem_rd;
    logic [`XLEN-1:0] mem_x_rs2, mem_exu_result;

    logic             wb_en, wb_valid;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;
    logic [31:0]      wb_pc;

    inst_decode u_inst_decode (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .pc(pc), .inst_ready(inst_ready),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rs1(rs1), .rs2(rs2),
        .ex_rd(mem_rd), .ex_rd_w_en(mem_rd_w_en), .ex_valid(mem_valid), .adv(mem_ready),
        .id_valid(id_valid), .id_funct3(id_funct3), .id_pc(id_pc), .id_inst(id_inst),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_x_rs1(id_x_rs1), .id_x_rs2(id_x_rs2),
        .id_imm(id_imm), .id_alu_op(id_alu_op), .id_rd(id_rd), .id_rd_idx_0(id_rd_idx_0),
        .id_rd_w_en(id_rd_w_en), .id_inst_load(id_inst_load), .id_inst_store(id_inst_store)
    );

    int_alu u_int_alu (
        .inst(id_inst), .alu_op(id_alu_op), .x_rs1(id_x_rs1), .x_rs2(id_x_rs2),
        .imm(id_imm), .inst_load(id_inst_load), .inst_store(id_inst_store),
        .exu_result(exu_result)
    );

    // The memory stage never stalls on its own, only through mem_idle.
    ex_mem_reg u_ex_mem_reg (
        .clk(clk), .reset(reset), .mem_idle(mem_idle),
        .in_valid(id_valid), .in_ready(1'b1), .in_funct3(id_funct3), .in_pc(id_pc),
        .in_inst(id_inst), .in_rs1(id_rs1), .in_rs2(id_rs2),
        .in_x_rs1(id_x_rs1), .in_x_rs2(id_x_rs2), .in_rd(id_rd),
        .in_rd_idx_0(id_rd_idx_0), .in_rd_w_en(id_rd_w_en), .in_exu_result(exu_result),
        .in_inst_load(id_inst_load), .in_inst_store(id_inst_store),
        .out_valid(mem_valid), .out_ready(mem_ready), .out_funct3(mem_funct3),
        .out_pc(mem_pc), .out_inst(), .out_rs1(), .out_rs2(),
        .out_x_rs1(), .out_x_rs2(mem_x_rs2), .out_rd(mem_rd),
        .out_rd_idx_0(mem_rd_idx_0), .out_rd_w_en(mem_rd_w_en),
        .out_exu_result(mem_exu_result), .out_inst_load(mem_inst_load),
        .out_inst_store(mem_inst_store)
    );

    data_mem_stage u_data_mem_stage (
        .clk(clk), .reset(reset), .in_valid(mem_valid), .funct3(mem_funct3),
        .pc(mem_pc), .rd(mem_rd), .rd_idx_0(mem_rd_idx_0), .rd_w_en(mem_rd_w_en),
        .x_rs2(mem_x_rs2), .exu_result(mem_exu_result),
        .inst_load(mem_inst_load), .inst_store(mem_inst_store),
        .mem_idle(mem_idle), .wb_en(wb_en), .wb_valid(wb_valid),
        .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_en(wb_en), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

`default_nettype wire

// ==== hw/data_mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module data_mem_stage
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [2:0]       funct3,
    input  logic [31:0]      pc,
    input  logic [4:0]       rd,
    input  logic             rd_idx_0,
    input  logic             rd_w_en,
    input  logic [`XLEN-1:0] x_rs2,
    input  logic [`XLEN-1:0] exu_result,
    input  logic             inst_load,
    input  logic             inst_store,
    output logic             mem_idle,
    output logic             wb_en,
    output logic             wb_valid,
    output logic [4:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic [31:0]      wb_pc
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] load_data;
    logic [31:0]      rword;
    logic [AW-1:0]    widx;
    mem_state_e       state;

    // Bit 2 picks the word within a doubleword.
    assign widx     = exu_result[AW+2:3];
    assign mem_idle = !(in_valid && inst_load && state == MEM_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MEM_IDLE;
        end else begin
            state <= (state == MEM_IDLE && !mem_idle) ? MEM_LOAD_WAIT : MEM_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && inst_store) begin
            if (funct3[1:0] == 2'b11) begin
                mem[widx] <= x_rs2;
            end else if (exu_result[2]) begin
                mem[widx][`XLEN-1:32] <= x_rs2[31:0];
            end else begin
                mem[widx][31:0] <= x_rs2[31:0];
            end
        end
        if (!mem_idle) begin
            rdata <= mem[widx];
        end
    end

    assign rword     = exu_result[2] ? rdata[`XLEN-1:32] : rdata[31:0];
    assign load_data = (funct3[1:0] == 2'b11) ? rdata : {{(`XLEN-32){rword[31]}}, rword};

    assign wb_valid = in_valid && (state == MEM_LOAD_WAIT || !inst_load);
    assign wb_en    = wb_valid && rd_w_en && !rd_idx_0;
    assign wb_rd    = rd_w_en ? rd : 5'd0;
    assign wb_data  = inst_load ? load_data : exu_result;
    assign wb_pc    = pc;

endmodule

`default_nettype wire

// ==== hw/ex_mem_reg.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module ex_mem_reg (
    input  logic             clk,
    input  logic             reset,
    input  logic             mem_idle,
    input  logic             in_valid,
    input  logic             in_ready,
    input  logic [2:0]       in_funct3,
    input  logic [31:0]      in_pc,
    input  logic [31:0]      in_inst,
    input  logic [4:0]       in_rs1,
    input  logic [4:0]       in_rs2,
    input  logic [`XLEN-1:0] in_x_rs1,
    input  logic [`XLEN-1:0] in_x_rs2,
    input  logic [4:0]       in_rd,
    input  logic             in_rd_idx_0,
    input  logic             in_rd_w_en,
    input  logic [`XLEN-1:0] in_exu_result,
    input  logic             in_inst_load,
    input  logic             in_inst_store,
    output logic             out_valid,
    output logic             out_ready,
    output logic [2:0]       out_funct3,
    output logic [31:0]      out_pc,
    output logic [31:0]      out_inst,
    output logic [4:0]       out_rs1,
    output logic [4:0]       out_rs2,
    output logic [`XLEN-1:0] out_x_rs1,
    output logic [`XLEN-1:0] out_x_rs2,
    output logic [4:0]       out_rd,
    output logic             out_rd_idx_0,
    output logic             out_rd_w_en,
    output logic [`XLEN-1:0] out_exu_result,
    output logic             out_inst_load,
    output logic             out_inst_store
);

    logic wen;
    logic ctrl_flush;

    // The memory stage holds this register while a load waits.
    assign out_ready  = in_ready && mem_idle;
    assign wen        = in_valid && out_ready;
    assign ctrl_flush = reset || (out_ready && !in_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_flush) begin
            out_rd_w_en    <= 1'b0;
            out_inst_load  <= 1'b0;
            out_inst_store <= 1'b0;
        end else if (wen) begin
            out_rd_w_en    <= in_rd_w_en;
            out_inst_load  <= in_inst_load;
            out_inst_store <= in_inst_store;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            out_funct3     <= in_funct3;
            out_pc         <= in_pc;
            out_inst       <= in_inst;
            out_rs1        <= in_rs1;
            out_rs2        <= in_rs2;
            out_x_rs1      <= in_x_rs1;
            out_x_rs2      <= in_x_rs2;
            out_rd         <= in_rd;
            out_rd_idx_0   <= in_rd_idx_0;
            out_exu_result <= in_exu_result;
        end
    end

endmodule

`default_nettype wire

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module inst_decode
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  logic [31:0]      inst,
    input  logic [31:0]      pc,
    output logic             inst_ready,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    input  logic [4:0]       ex_rd,
    input  logic             ex_rd_w_en,
    input  logic             ex_valid,
    input  logic             adv,
    output logic             id_valid,
    output logic [2:0]       id_funct3,
    output logic [31:0]      id_pc,
    output logic [31:0]      id_inst,
    output logic [4:0]       id_rs1,
    output logic [4:0]       id_rs2,
    output logic [`XLEN-1:0] id_x_rs1,
    output logic [`XLEN-1:0] id_x_rs2,
    output logic [`XLEN-1:0] id_imm,
    output alu_op_e          id_alu_op,
    output logic [4:0]       id_rd,
    output logic             id_rd_idx_0,
    output logic             id_rd_w_en,
    output logic             id_inst_load,
    output logic             id_inst_store
);

    opcode_e          opcode;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             writes_rd;
    logic             stall;
    logic             advance;
    logic             accept;

    // Scoreboard lookup against both in-flight stages.
    function automatic logic busy(input logic [4:0] idx);
        busy = (idx != 5'd0) &&
               ((id_valid && id_rd_w_en && id_rd == idx) ||
                (ex_valid && ex_rd_w_en && ex_rd == idx));
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        uses_rs1  = opcode inside {OP, OP_IMM, LOAD, STORE};
        uses_rs2  = opcode inside {OP, STORE};
        writes_rd = opcode inside {OP, OP_IMM, LUI, LOAD};
        stall     = (uses_rs1 && busy(rs1)) || (uses_rs2 && busy(rs2));
    end

    assign advance    = !id_valid || adv;
    assign inst_ready = advance && !stall;
    assign accept     = inst_valid && inst_ready;

    always_comb begin
        case (inst[14:12])
            3'b000:  alu_op = (opcode == OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (opcode == LUI) begin
            alu_op = ALU_PASS;
        end
    end

    always_comb begin
        case (opcode)
            STORE:   imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            LUI:     imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            default: imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        endcase
    end

    // A stalled slot leaves as a bubble with its control flags cleared.
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid      <= 1'b0;
            id_rd_w_en    <= 1'b0;
            id_inst_load  <= 1'b0;
            id_inst_store <= 1'b0;
        end else if (advance) begin
            id_valid      <= accept;
            id_rd_w_en    <= accept && writes_rd;
            id_inst_load  <= accept && opcode == LOAD;
            id_inst_store <= accept && opcode == STORE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_funct3   <= inst[14:12];
            id_pc       <= pc;
            id_inst     <= inst;
            id_rs1      <= rs1;
            id_rs2      <= rs2;
            id_x_rs1    <= rs1_data;
            id_x_rs2    <= rs2_data;
            id_imm      <= imm;
            id_alu_op   <= alu_op;
            id_rd       <= inst[11:7];
            id_rd_idx_0 <= inst[11:7] == 5'd0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_alu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module int_alu
    import rv_pkg::*;
(
    input  logic [31:0]      inst,
    input  alu_op_e          alu_op,
    input  logic [`XLEN-1:0] x_rs1,
    input  logic [`XLEN-1:0] x_rs2,
    input  logic [`XLEN-1:0] imm,
    input  logic             inst_load,
    input  logic             inst_store,
    output logic [`XLEN-1:0] exu_result
);

    logic [`XLEN-1:0] op2;
    logic [5:0]       shamt;

    // Register form takes rs2, every other form the immediate.
    assign op2   = (opcode_e'(inst[6:0]) == OP) ? x_rs2 : imm;
    assign shamt = op2[5:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  exu_result = x_rs1 + op2;
            ALU_SUB:  exu_result = x_rs1 - op2;
            ALU_SLL:  exu_result = x_rs1 << shamt;
            ALU_SLT:  exu_result = {{(`XLEN-1){1'b0}}, $signed(x_rs1) < $signed(op2)};
            ALU_SLTU: exu_result = {{(`XLEN-1){1'b0}}, x_rs1 < op2};
            ALU_XOR:  exu_result = x_rs1 ^ op2;
            ALU_SRL:  exu_result = x_rs1 >> shamt;
            ALU_SRA:  exu_result = $unsigned($signed(x_rs1) >>> shamt);
            ALU_OR:   exu_result = x_rs1 | op2;
            ALU_AND:  exu_result = x_rs1 & op2;
            default:  exu_result = imm;
        endcase
        // Memory access address.
        if (inst_load || inst_store) begin
            exu_result = x_rs1 + imm;
        end
    end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    input  logic             wb_en,
    input  logic             wb_valid,
    input  logic [4:0]       wb_rd,
    input  logic [`XLEN-1:0] wb_data,
    input  logic [31:0]      wb_pc,
    output logic             retire_valid,
    output logic [31:0]      retire_pc,
    output logic [4:0]       retire_rd,
    output logic [`XLEN-1:0] retire_data
);

    // x0 has no storage.
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_pc   <= wb_pc;
            retire_rd   <= wb_rd;
            retire_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Integer register width.
`define XLEN 64

// Architectural registers, x0 included.
`define REG_COUNT 32

// Data memory depth in 64-bit words.
`define DMEM_WORDS 256

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS
    } alu_op_e;

    // Loads spend one extra cycle in the memory stage.
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_LOAD_WAIT
    } mem_state_e;

endpackage

`default_nettype wire

// ==== sim/core_backend_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module core_backend_tb
    import rv_pkg::*;
();

    // About 130 instructions at four cycles or less each, with wide margin.
    localparam int TIMEOUT_CYCLES = 2000;

    logic             clk;
    logic             reset;
    logic             inst_valid;
    logic [31:0]      inst;
    logic [31:0]      pc;
    logic             inst_ready;
    logic             retire_valid;
    logic [31:0]      retire_pc;
    logic [4:0]       retire_rd;
    logic [`XLEN-1:0] retire_data;

    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [`XLEN-1:0] model_mem [`DMEM_WORDS];
    logic [31:0]      next_pc;
    int               cycles;

    // Outstanding retire records, oldest first.
    logic [31:0]      exp_pc [$];
    logic [4:0]       exp_rd [$];
    logic [`XLEN-1:0] exp_data [$];
    bit               exp_chk [$];

    core_backend dut0 (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst), .pc(pc),
        .inst_ready(inst_ready), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout.");
        end
    end

    task automatic check(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch.");
        end
    endtask

    task automatic compare_retire();
        bit               chk;
        logic [`XLEN-1:0] data;
        if (exp_pc.size() == 0) begin
            $display("A retire at pc %h came with no instruction outstanding.", retire_pc);
            $display("ERRORS FOUND");
            $fatal(1, "Extra retire.");
        end else begin
            chk  = exp_chk.pop_front();
            data = exp_data.pop_front();
            check(retire_pc, exp_pc.pop_front(), "retire_pc");
            check(retire_rd, exp_rd.pop_front(), "retire_rd");
            if (chk) begin
                check(retire_data, data, "retire_data");
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            compare_retire();
        end
    end

    function automatic logic [`XLEN-1:0] sext12(input logic [11:0] imm);
        return {{(`XLEN-12){imm[11]}}, imm};
    endfunction

    // Register-register semantics keyed by funct3 and bit 30.
    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: return (a < b) ? 64'd1 : 64'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void write_model(input logic [4:0] rd, input logic [`XLEN-1:0] v);
        if (rd != 5'd0) begin
            model_regs[rd] = v;
        end
    endfunction

    // Called right after a rising edge; returns on the edge that accepts the word.
    task automatic issue(input logic [31:0] word, input logic [4:0] rd,
                         input logic [`XLEN-1:0] data, input bit chk);
        inst_valid <= 1'b1;
        inst       <= word;
        pc         <= next_pc;
        @(negedge clk);
        while (!inst_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        exp_pc.push_back(next_pc);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_chk.push_back(chk);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drain();
        inst_valid <= 1'b0;
        while (exp_pc.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        logic [`XLEN-1:0] r;
        r = alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]);
        issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP}, rd, r, rd != 5'd0);
        write_model(rd, r);
    endtask

    task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [`XLEN-1:0] r;
        r = model_regs[rs1] + sext12(imm);
        issue({imm, rs1, 3'b000, rd, OP_IMM}, rd, r, rd != 5'd0);
        write_model(rd, r);
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
        logic [`XLEN-1:0] r;
        r = {{(`XLEN-32){imm[19]}}, imm, 12'b0};
        issue({imm, rd, LUI}, rd, r, rd != 5'd0);
        write_model(rd, r);
    endtask

    // LD when dw is set, LW otherwise. Address bits 10:3 pick the doubleword.
    task automatic load(input bit dw, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] r;
        logic [31:0]      w;
        addr = model_regs[rs1] + sext12(imm);
        r    = model_mem[addr[10:3]];
        w    = addr[2] ? r[63:32] : r[31:0];
        if (!dw) begin
            r = {{(`XLEN-32){w[31]}}, w};
        end
        issue({imm, rs1, 2'b01, dw, rd, LOAD}, rd, r, rd != 5'd0);
        write_model(rd, r);
    endtask

    task automatic store(input bit dw, input logic [4:0] rs2, input logic [4:0] rs1,
                         input logic [11:0] imm);
        logic [`XLEN-1:0] addr;
        addr = model_regs[rs1] + sext12(imm);
        if (dw) begin
            model_mem[addr[10:3]] = model_regs[rs2];
        end else if (addr[2]) begin
            model_mem[addr[10:3]][63:32] = model_regs[rs2][31:0];
        end else begin
            model_mem[addr[10:3]][31:0] = model_regs[rs2][31:0];
        end
        issue({imm[11:5], rs2, rs1, 2'b01, dw, imm[4:0], STORE}, 5'd0, '0, 1'b0);
    endtask

    task automatic alu_test();
        for (int i = 1; i <= 8; i++) begin
            lui(5'(i), 20'($urandom()));
            addi(5'(i), 5'(i), 12'($urandom()));
        end
        // Build full 64-bit operands from the 32-bit ones.
        addi(5'd31, 5'd0, 12'd32);
        op_rr(3'd1, 1'b0, 5'd9, 5'd1, 5'd31);
        op_rr(3'd4, 1'b0, 5'd10, 5'd9, 5'd2);
        op_rr(3'd1, 1'b0, 5'd11, 5'd3, 5'd31);
        op_rr(3'd6, 1'b0, 5'd11, 5'd11, 5'd4);
        addi(5'd12, 5'd0, 12'hffb);
        addi(5'd13, 5'd0, 12'd7);
        // k holds {bit 30, funct3}; only ADD/SUB and SRL/SRA use bit 30.
        for (int k = 0; k < 16; k++) begin
            if (k < 9 || k == 13) begin
                op_rr(k[2:0], k[3], 5'd20, 5'd10, 5'd11);
                op_rr(k[2:0], k[3], 5'd21, 5'd12, 5'd13);
                op_rr(k[2:0], k[3], 5'd22, 5'd13, 5'd12);
            end
        end
        drain();
    endtask

    task automatic lui_x0_test();
        lui(5'd5, 20'h80000);
        lui(5'd6, 20'h7ffff);
        lui(5'd7, 20'($urandom()));
        addi(5'd0, 5'd5, 12'h123);
        lui(5'd0, 20'h12345);
        op_rr(3'd0, 1'b0, 5'd8, 5'd0, 5'd6);
        addi(5'd9, 5'd0, 12'h000);
        drain();
    endtask

    task automatic mem_test();
        addi(5'd15, 5'd0, 12'h100);
        store(1'b1, 5'd10, 5'd15, 12'd0);
        load(1'b1, 5'd16, 5'd15, 12'd0);
        store(1'b0, 5'd12, 5'd15, 12'd8);
        store(1'b0, 5'd5, 5'd15, 12'd12);
        load(1'b0, 5'd17, 5'd15, 12'd8);
        load(1'b0, 5'd18, 5'd15, 12'd12);
        load(1'b1, 5'd19, 5'd15, 12'd8);
        store(1'b0, 5'd13, 5'd15, 12'd4);
        load(1'b1, 5'd16, 5'd15, 12'd0);
        load(1'b0, 5'd17, 5'd15, 12'd0);
        store(1'b1, 5'd11, 5'd15, 12'd16);
        load(1'b1, 5'd18, 5'd15, 12'd16);
        load(1'b1, 5'd19, 5'd15, 12'd0);
        drain();
    endtask

    task automatic chain_test();
        addi(5'd1, 5'd0, 12'd1);
        for (int i = 0; i < 8; i++) begin
            op_rr(3'd0, 1'b0, 5'd1, 5'd1, 5'd1);
        end
        addi(5'd2, 5'd1, 12'hffd);
        op_rr(3'd0, 1'b1, 5'd3, 5'd2, 5'd1);
        op_rr(3'd4, 1'b0, 5'd3, 5'd3, 5'd2);
        // Load-use pairs through memory.
        store(1'b1, 5'd3, 5'd15, 12'd24);
        load(1'b1, 5'd4, 5'd15, 12'd24);
        addi(5'd4, 5'd4, 12'd5);
        store(1'b0, 5'd4, 5'd15, 12'd32);
        load(1'b0, 5'd20, 5'd15, 12'd32);
        op_rr(3'd0, 1'b0, 5'd21, 5'd20, 5'd4);
        drain();
    endtask

    task automatic stream_test();
        logic [4:0] rd;
        for (int n = 0; n < 24; n++) begin
            rd = 5'(24 + n % 6);
            case ($urandom_range(3, 0))
                0: addi(rd, 5'(10 + $urandom_range(3, 0)), 12'($urandom()));
                1: op_rr(3'($urandom()), 1'b0, rd, 5'(10 + $urandom_range(3, 0)),
                         5'(10 + $urandom_range(3, 0)));
                2: load(1'b1, rd, 5'd15, 12'($urandom_range(3, 0) * 8));
                default: load(1'b0, rd, 5'd15, 12'($urandom_range(3, 0) * 4));
            endcase
        end
        drain();
    endtask

    task automatic reset_test();
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < 5; n++) begin
            @(negedge clk);
            check(retire_valid, 1'b0, "retire_valid after reset");
            check(inst_ready, 1'b1, "inst_ready after reset");
        end
        @(posedge clk);
    endtask

    initial begin
        int seed;
        seed          = $urandom(36);
        clk           = 1'b0;
        reset         = 1'b1;
        inst_valid    = 1'b0;
        inst          = '0;
        pc            = '0;
        next_pc       = 32'h1000;
        cycles        = 0;
        model_regs[0] = '0;
        reset_test();
        alu_test();
        lui_x0_test();
        mem_test();
        chain_test();
        stream_test();
        reset_test();
        addi(5'd30, 5'd13, 12'd1);
        drain();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/rv_pkg.sv
hw/inst_decode.sv
hw/int_alu.sv
hw/ex_mem_reg.sv
hw/data_mem_stage.sv
hw/reg_file.sv
hw/core_backend.sv
sim/core_backend_tb.sv
